/* hw/gb_types_pkg.sv */
package gb_types_pkg;

  // ================================================
  // Machine cycle phases
  // ================================================

  // Four T-phases per machine cycle
  // T1 is where the deferred TIMA reload lands
  typedef enum logic [1:0] {
    T1 = 2'd0,
    T2 = 2'd1,
    T3 = 2'd2,
    T4 = 2'd3
  } t_phase_t;

  // ================================================
  // Interrupt sources
  // ================================================

  // Value doubles as the bit index in IF and IE
  // Lower index means higher priority
  typedef enum logic [2:0] {
    VBLANK = 3'd0,
    LCD    = 3'd1,
    TIMER  = 3'd2,
    SERIAL = 3'd3,
    JOYPAD = 3'd4
  } irq_src_t;

endpackage

/* hw/gb_io_map_pkg.sv */
package gb_io_map_pkg;

  // ================================================
  // Register addresses
  // ================================================

  // Timer block, contiguous range
  localparam logic [15:0] ADDR_DIV  = 16'hFF04;
  localparam logic [15:0] ADDR_TIMA = 16'hFF05;
  localparam logic [15:0] ADDR_TMA  = 16'hFF06;
  localparam logic [15:0] ADDR_TAC  = 16'hFF07;

  // Interrupt flag and enable
  localparam logic [15:0] ADDR_IF   = 16'hFF0F;
  localparam logic [15:0] ADDR_IE   = 16'hFFFF;

  // ================================================
  // Values and masks
  // ================================================

  // Unused TAC bits, always one
  localparam logic [7:0]  TAC_FIXED_ONES  = 8'b1111_1000;
  // Upper IF bits have no source behind them
  localparam logic [7:0]  IF_FIXED_ONES   = 8'b1110_0000;
  // What DIV holds right after a write
  localparam logic [15:0] DIV_WRITE_VALUE = 16'd4;
  // Nothing drives the bus
  localparam logic [7:0]  OPEN_BUS        = 8'hFF;

endpackage

/* hw/phase_sequencer.sv */
module phase_sequencer
  import gb_types_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     stop,
  output t_phase_t t_phase,
  output logic     run
);

  t_phase_t phase_next;

  // Next T-phase, wraps T4 back to T1
  always_comb begin
    unique case (t_phase)
      T1:      phase_next = T2;
      T2:      phase_next = T3;
      T3:      phase_next = T4;
      default: phase_next = T1;
    endcase
  end

  // ================================================
  // Phase and run level
  // ================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      t_phase <= T1;
      // Low for the first cycle out of reset
      run     <= 1'b0;
    end else begin
      // Phase holds during STOP
      if (!stop) begin
        t_phase <= phase_next;
      end
      // Run trails stop by one cycle
      run <= !stop;
    end
  end

endmodule

/* hw/timer.sv */
module timer
  import gb_types_pkg::*;
  import gb_io_map_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  t_phase_t    t_phase,
  input  logic        run,
  input  logic [15:0] addr,
  input  logic [7:0]  wdata,
  input  logic        write_en,
  input  logic        read_en,
  output logic [7:0]  timer_rdata,
  output logic        timer_hit,
  output logic        timer_req
);

  // 16-bit divider, only the upper byte is visible
  logic [15:0] div_q;
  logic [7:0]  tima_q;
  logic [7:0]  tma_q;
  logic [7:0]  tac_q;

  // Tick detection
  logic tap_bit;
  logic sel_bit;
  logic sel_bit_q;
  logic tick;

  // Overflow handling
  logic overflow_pending;
  logic reload;

  // Write strobes per register
  logic div_wr;
  logic tima_wr;
  logic tma_wr;
  logic tac_wr;

  assign div_wr  = write_en && (addr == ADDR_DIV);
  assign tima_wr = write_en && (addr == ADDR_TIMA);
  assign tma_wr  = write_en && (addr == ADDR_TMA);
  assign tac_wr  = write_en && (addr == ADDR_TAC);

  // ================================================
  // Rate select and falling edge
  // ================================================

  // TAC[1:0] picks the divider tap
  always_comb begin
    unique case (tac_q[1:0])
      2'b00:   tap_bit = div_q[9];
      2'b01:   tap_bit = div_q[3];
      2'b10:   tap_bit = div_q[5];
      default: tap_bit = div_q[7];
    endcase
  end

  // Enable gates before the edge detect, so clearing TAC[2] can tick too
  assign sel_bit = tap_bit & tac_q[2];
  assign tick    = run && sel_bit_q && !sel_bit;

  // Deferred reload waits for the next T1
  assign reload  = run && overflow_pending && (t_phase == T1);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      div_q     <= '0;
      sel_bit_q <= 1'b0;
    end else begin
      // DIV write blocks the increment in that cycle
      if (div_wr) begin
        div_q <= DIV_WRITE_VALUE;
      end else if (run) begin
        div_q <= div_q + 16'd1;
      end
      if (run) begin
        sel_bit_q <= sel_bit;
      end
    end
  end

  // ================================================
  // TIMA, overflow and reload
  // ================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tima_q           <= '0;
      overflow_pending <= 1'b0;
      timer_req        <= 1'b0;
    end else begin
      // One-cycle request pulse
      timer_req <= 1'b0;
      if (reload) begin
        overflow_pending <= 1'b0;
        tima_q           <= tma_q;
        timer_req        <= 1'b1;
      end else if (tick) begin
        if (tima_q == 8'hFF) begin
          // Reads zero until the reload
          tima_q           <= 8'h00;
          overflow_pending <= 1'b1;
        end else begin
          tima_q <= tima_q + 8'h01;
        end
      end
      // Bus write beats the tick
      if (tima_wr) begin
        tima_q <= wdata;
      end
    end
  end

  // Modulo and control
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tma_q <= '0;
      tac_q <= TAC_FIXED_ONES;
    end else begin
      if (tma_wr) begin
        tma_q <= wdata;
      end
      if (tac_wr) begin
        tac_q <= wdata | TAC_FIXED_ONES;
      end
    end
  end

  // ================================================
  // Read side
  // ================================================

  assign timer_hit = (addr >= ADDR_DIV) && (addr <= ADDR_TAC);

  always_comb begin
    timer_rdata = OPEN_BUS;
    if (read_en) begin
      unique case (addr)
        ADDR_DIV:  timer_rdata = div_q[15:8];
        ADDR_TIMA: timer_rdata = tima_q;
        ADDR_TMA:  timer_rdata = tma_q;
        ADDR_TAC:  timer_rdata = tac_q;
        default:   timer_rdata = OPEN_BUS;
      endcase
    end
  end

endmodule

/* hw/interrupt_ctrl.sv */
module interrupt_ctrl
  import gb_types_pkg::*;
  import gb_io_map_pkg::*;
#(
  parameter int IRQ_COUNT = 5
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [15:0]          addr,
  input  logic [7:0]           wdata,
  input  logic                 write_en,
  input  logic                 read_en,
  input  logic [IRQ_COUNT-1:0] ext_req,
  input  logic                 timer_req,
  input  logic                 irq_ack,
  input  logic [7:0]           timer_rdata,
  input  logic                 timer_hit,
  output logic                 irq,
  output irq_src_t             irq_vector,
  output logic [7:0]           rdata
);

  logic [IRQ_COUNT-1:0] if_q;
  logic [IRQ_COUNT-1:0] ie_q;
  logic [IRQ_COUNT-1:0] req;
  logic [IRQ_COUNT-1:0] pending;
  logic [IRQ_COUNT-1:0] ack_clear;
  // Padded copies so any IRQ_COUNT maps onto the 8-bit bus
  logic [IRQ_COUNT+7:0] wdata_ext;
  logic [IRQ_COUNT+7:0] if_ext;
  logic [IRQ_COUNT+7:0] ie_ext;

  assign wdata_ext = {{IRQ_COUNT{1'b0}}, wdata};
  assign if_ext    = {8'h00, if_q};
  assign ie_ext    = {8'h00, ie_q};

  // ================================================
  // Request merge and priority
  // ================================================

  // Timer slot comes from the timer, ext_req bit there is ignored
  always_comb begin
    for (int i = 0; i < IRQ_COUNT; i++) begin
      req[i] = (i == int'(TIMER)) ? timer_req : ext_req[i];
    end
  end

  assign pending = if_q & ie_q;
  assign irq     = |pending;

  // Scan downwards so the lowest index ends up selected
  always_comb begin
    irq_vector = VBLANK;
    for (int i = IRQ_COUNT - 1; i >= 0; i--) begin
      if (pending[i]) begin
        irq_vector = irq_src_t'(3'(i));
      end
    end
  end

  // Ack only clears a source that is actually being reported
  always_comb begin
    for (int i = 0; i < IRQ_COUNT; i++) begin
      ack_clear[i] = irq_ack && irq && (i == int'(irq_vector));
    end
  end

  // ================================================
  // IF and IE registers
  // ================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      if_q <= '0;
      ie_q <= '0;
    end else begin
      // New request wins over write and ack clear
      if (write_en && (addr == ADDR_IF)) begin
        if_q <= wdata_ext[IRQ_COUNT-1:0] | req;
      end else begin
        if_q <= (if_q & ~ack_clear) | req;
      end
      if (write_en && (addr == ADDR_IE)) begin
        ie_q <= wdata_ext[IRQ_COUNT-1:0];
      end
    end
  end

  // Read merge for the whole slice
  always_comb begin
    rdata = OPEN_BUS;
    if (read_en) begin
      if (addr == ADDR_IF) begin
        rdata = if_ext[7:0] | IF_FIXED_ONES;
      end else if (addr == ADDR_IE) begin
        rdata = ie_ext[7:0];
      end else if (timer_hit) begin
        rdata = timer_rdata;
      end
    end
  end

endmodule

/* hw/gb_timer_io.sv */
module gb_timer_io
  import gb_types_pkg::*;
#(
  parameter int IRQ_COUNT = 5
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stop,
  input  logic [15:0]          addr,
  input  logic [7:0]           wdata,
  input  logic                 write_en,
  input  logic                 read_en,
  output logic [7:0]           rdata,
  input  logic [IRQ_COUNT-1:0] ext_req,
  input  logic                 irq_ack,
  output logic                 irq,
  output irq_src_t             irq_vector
);

  // Sequencer to timer
  t_phase_t   t_phase;
  logic       run;

  // Timer to interrupt controller
  logic       timer_req;
  logic [7:0] timer_rdata;
  logic       timer_hit;

  // ================================================
  // Instances
  // ================================================

  phase_sequencer u_phase_sequencer (
    .clk     (clk),
    .reset   (reset),
    .stop    (stop),
    .t_phase (t_phase),
    .run     (run)
  );

  timer u_timer (
    .clk         (clk),
    .reset       (reset),
    .t_phase     (t_phase),
    .run         (run),
    .addr        (addr),
    .wdata       (wdata),
    .write_en    (write_en),
    .read_en     (read_en),
    .timer_rdata (timer_rdata),
    .timer_hit   (timer_hit),
    .timer_req   (timer_req)
  );

  // Also the bus endpoint for reads
  interrupt_ctrl #(
    .IRQ_COUNT (IRQ_COUNT)
  ) u_interrupt_ctrl (
    .clk         (clk),
    .reset       (reset),
    .addr        (addr),
    .wdata       (wdata),
    .write_en    (write_en),
    .read_en     (read_en),
    .ext_req     (ext_req),
    .timer_req   (timer_req),
    .irq_ack     (irq_ack),
    .timer_rdata (timer_rdata),
    .timer_hit   (timer_hit),
    .irq         (irq),
    .irq_vector  (irq_vector),
    .rdata       (rdata)
  );

endmodule

/* test/timer_checker.sv */
module timer_checker
  import gb_io_map_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        stop,
  input  logic [15:0] addr,
  input  logic [7:0]  wdata,
  input  logic        write_en,
  input  logic        read_en,
  input  logic [4:0]  ext_req,
  input  logic        irq_ack,
  input  logic [7:0]  rdata,
  input  logic        irq,
  input  logic [2:0]  irq_vector,
  output int          check_count,
  output int          error_count
);

  // ================================================
  // Model state, mirrors the DUT after each edge
  // ================================================

  logic [1:0]  m_phase;
  logic        m_run;
  logic [15:0] m_div;
  logic [7:0]  m_tima;
  logic [7:0]  m_tma;
  logic [7:0]  m_tac;
  // Last registered value of the selected DIV bit
  logic        m_sel_q;
  // Overflow waiting for T1
  logic        m_pend;
  logic        m_treq;
  logic [4:0]  m_if;
  logic [4:0]  m_ie;

  // Read value that the bus should show for an address
  function automatic logic [7:0] expected_read(input logic [15:0] a);
    case (a)
      ADDR_DIV:  return m_div[15:8];
      ADDR_TIMA: return m_tima;
      ADDR_TMA:  return m_tma;
      ADDR_TAC:  return m_tac;
      ADDR_IF:   return {3'b000, m_if} | IF_FIXED_ONES;
      ADDR_IE:   return {3'b000, m_ie};
      default:   return OPEN_BUS;
    endcase
  endfunction

  task automatic compare_byte(input string name, input logic [7:0] expv,
                              input logic [7:0] actv);
    check_count = check_count + 1;
    if (expv !== actv) begin
      error_count = error_count + 1;
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expv, actv);
    end
  endtask

  // Compare and step at the falling edge, where inputs and outputs are settled
  always @(negedge clk) begin : model_step
    logic [4:0] pend_bits;
    logic [2:0] vec;
    logic       exp_irq;
    logic       tap;
    logic       sel;
    logic       tick;
    logic       reload;
    logic [4:0] req;
    logic [4:0] clr;
    if (reset) begin
      m_phase = 2'd0;
      m_run   = 1'b0;
      m_div   = 16'd0;
      m_tima  = 8'd0;
      m_tma   = 8'd0;
      m_tac   = TAC_FIXED_ONES;
      m_sel_q = 1'b0;
      m_pend  = 1'b0;
      m_treq  = 1'b0;
      m_if    = 5'd0;
      m_ie    = 5'd0;
    end else begin
      // Interrupt view of the current state
      pend_bits = m_if & m_ie;
      exp_irq   = |pend_bits;
      vec       = 3'd0;
      for (int i = 4; i >= 0; i--) begin
        if (pend_bits[i]) begin
          vec = 3'(i);
        end
      end
      // Output checks
      compare_byte("rdata", read_en ? expected_read(addr) : OPEN_BUS, rdata);
      compare_byte("irq", {7'd0, exp_irq}, {7'd0, irq});
      if (exp_irq) begin
        compare_byte("irq_vector", {5'd0, vec}, {5'd0, irq_vector});
      end

      // Tap select: 00 -> bit 9, 01 -> bit 3, 10 -> bit 5, 11 -> bit 7
      case (m_tac[1:0])
        2'b00:   tap = m_div[9];
        2'b01:   tap = m_div[3];
        2'b10:   tap = m_div[5];
        default: tap = m_div[7];
      endcase
      sel    = tap & m_tac[2];
      tick   = m_run & m_sel_q & ~sel;
      reload = m_run & m_pend & (m_phase == 2'd0);
      // Timer slot of ext_req is replaced
      req    = ext_req;
      req[2] = m_treq;
      clr    = 5'd0;
      if (irq_ack && exp_irq) begin
        clr[vec] = 1'b1;
      end

      // ================================================
      // Next state
      // ================================================
      m_treq = reload;
      if (reload) begin
        m_tima = m_tma;
        m_pend = 1'b0;
      end else if (tick) begin
        if (m_tima == 8'hFF) begin
          m_tima = 8'h00;
          m_pend = 1'b1;
        end else begin
          m_tima = m_tima + 8'd1;
        end
      end
      // Bus write wins over tick
      if (write_en && addr == ADDR_TIMA) m_tima = wdata;
      if (write_en && addr == ADDR_TMA) m_tma = wdata;
      if (write_en && addr == ADDR_TAC) m_tac = wdata | TAC_FIXED_ONES;
      if (m_run) m_sel_q = sel;
      if (write_en && addr == ADDR_DIV) begin
        m_div = DIV_WRITE_VALUE;
      end else if (m_run) begin
        m_div = m_div + 16'd1;
      end
      // Request beats write and ack
      if (write_en && addr == ADDR_IF) begin
        m_if = wdata[4:0] | req;
      end else begin
        m_if = (m_if & ~clr) | req;
      end
      if (write_en && addr == ADDR_IE) m_ie = wdata[4:0];
      if (!stop) m_phase = m_phase + 2'd1;
      // run last, the steps above use the old level
      m_run = ~stop;
    end
  end

endmodule

/* test/tb_gb_timer_io.sv */
module tb_gb_timer_io
  import gb_types_pkg::*;
  import gb_io_map_pkg::*;
();

  // ================================================
  // Run length
  // ================================================

  localparam int RESET_CYCLES = 8;
  localparam int LEN_PROBE    = 10 + 1;
  localparam int LEN_DIV      = 1200;
  localparam int TAC_ROUNDS   = 8;
  localparam int TAC_STRETCH  = 600;
  localparam int OVF_ROUNDS   = 12;
  localparam int OVF_STRETCH  = 120;
  localparam int LEN_IRQ      = 1500;
  localparam int LEN_STOP     = 2000;
  // Idle cycle at the end of every test included
  localparam int TOTAL_CYCLES = RESET_CYCLES + LEN_PROBE + (LEN_DIV + 1)
                              + (TAC_ROUNDS * (TAC_STRETCH + 1) + 1)
                              + (OVF_ROUNDS * (OVF_STRETCH + 5) + 1)
                              + (LEN_IRQ + 1) + (LEN_STOP + 4 + 1);
  localparam int CYCLE_LIMIT  = TOTAL_CYCLES + TOTAL_CYCLES / 10;

  logic        clk;
  logic        reset;
  logic        stop;
  logic [15:0] addr;
  logic [7:0]  wdata;
  logic        write_en;
  logic        read_en;
  logic [7:0]  rdata;
  logic [4:0]  ext_req;
  logic        irq_ack;
  logic        irq;
  irq_src_t    irq_vector;

  logic [31:0] rng;
  int          cycle_count;
  int          check_count;
  int          error_count;
  int          errors_at_start;
  int          tests_passed;
  int          tests_failed;

  gb_timer_io #(
    .IRQ_COUNT (5)
  ) UUT (
    .clk        (clk),
    .reset      (reset),
    .stop       (stop),
    .addr       (addr),
    .wdata      (wdata),
    .write_en   (write_en),
    .read_en    (read_en),
    .rdata      (rdata),
    .ext_req    (ext_req),
    .irq_ack    (irq_ack),
    .irq        (irq),
    .irq_vector (irq_vector)
  );

  timer_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .stop        (stop),
    .addr        (addr),
    .wdata       (wdata),
    .write_en    (write_en),
    .read_en     (read_en),
    .ext_req     (ext_req),
    .irq_ack     (irq_ack),
    .rdata       (rdata),
    .irq         (irq),
    .irq_vector  (irq_vector),
    .check_count (check_count),
    .error_count (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Hard limit on the whole run
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // One bus cycle with all inputs applied at the rising edge
  task automatic drive(input logic we, input logic re, input logic [15:0] a,
                       input logic [7:0] d, input logic [4:0] ext, input logic ack,
                       input logic stp);
    @(posedge clk);
    write_en <= we;
    read_en  <= re;
    addr     <= a;
    wdata    <= d;
    ext_req  <= ext;
    irq_ack  <= ack;
    stop     <= stp;
  endtask

  task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
    drive(1'b1, 1'b0, a, d, 5'd0, 1'b0, 1'b0);
  endtask

  task automatic read_reg(input logic [15:0] a);
    drive(1'b0, 1'b1, a, 8'h00, 5'd0, 1'b0, 1'b0);
  endtask

  // Idle cycle lets the last checks land before the tally
  task automatic end_test(input string name);
    int errs;
    drive(1'b0, 1'b0, 16'h0000, 8'h00, 5'd0, 1'b0, 1'b0);
    errs = error_count - errors_at_start;
    if (errs == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("test %s done, %0d errors", name, errs);
    errors_at_start = error_count;
  endtask

  // ================================================
  // Tests
  // ================================================

  task automatic probe_reset_values();
    logic [15:0] probe [10];
    probe = '{ADDR_DIV, ADDR_TIMA, ADDR_TMA, ADDR_TAC, ADDR_IF, ADDR_IE,
              16'h0000, 16'hFF03, 16'hFF08, 16'hFF10};
    for (int i = 0; i < 10; i++) begin
      read_reg(probe[i]);
    end
    end_test("reset_values");
  endtask

  // Gaps of 260 cycles or more, so the upper byte moves between DIV writes
  task automatic exercise_div();
    int gap;
    rng = lcg_next(rng);
    gap = int'(rng[23:16]);
    for (int i = 0; i < LEN_DIV; i++) begin
      rng = lcg_next(rng);
      if (gap == 0) begin
        write_reg(ADDR_DIV, rng[15:8]);
        gap = 260 + int'(rng[23:16]);
      end else begin
        read_reg(ADDR_DIV);
        gap--;
      end
    end
    end_test("div_counting");
  endtask

  // Enable alternates while rate and upper bits are random
  task automatic sweep_tac_rates();
    for (int k = 0; k < TAC_ROUNDS; k++) begin
      rng = lcg_next(rng);
      write_reg(ADDR_TAC, {rng[23:19], k[0], rng[17:16]});
      for (int i = 0; i < TAC_STRETCH; i++) begin
        rng = lcg_next(rng);
        read_reg(rng[31:29] == 3'd0 ? ADDR_DIV : ADDR_TIMA);
      end
    end
    end_test("tac_rates");
  endtask

  task automatic force_overflows();
    for (int k = 0; k < OVF_ROUNDS; k++) begin
      rng = lcg_next(rng);
      write_reg(ADDR_IF, 8'h00);
      // Fastest tap is bit 3
      write_reg(ADDR_TAC, 8'h05);
      write_reg(ADDR_TMA, rng[23:16]);
      write_reg(ADDR_IE, 8'h04);
      write_reg(ADDR_TIMA, {6'b111111, rng[25:24]});
      for (int i = 0; i < OVF_STRETCH; i++) begin
        read_reg(i[0] ? ADDR_IF : ADDR_TIMA);
      end
    end
    end_test("overflow_reload");
  endtask

  task automatic stress_irq_priority();
    logic [4:0] ext;
    logic       ack;
    for (int i = 0; i < LEN_IRQ; i++) begin
      rng = lcg_next(rng);
      // Each source pulses about one cycle in eight
      for (int b = 0; b < 5; b++) begin
        ext[b] = (rng[3*b +: 3] == 3'd0);
      end
      ack = (rng[16:15] == 2'd0);
      case (rng[31:28])
        4'd0:    drive(1'b1, 1'b0, ADDR_IE, {3'b000, rng[21:17]}, ext, ack, 1'b0);
        4'd1:    drive(1'b1, 1'b0, ADDR_IF, {3'b000, rng[21:17]}, ext, ack, 1'b0);
        default: drive(1'b0, 1'b1, rng[27] ? ADDR_IF : ADDR_IE, 8'h00, ext, ack, 1'b0);
      endcase
    end
    end_test("irq_priority");
  endtask

  task automatic toggle_stop();
    logic stp;
    logic ack;
    stp = 1'b0;
    rng = lcg_next(rng);
    write_reg(ADDR_TAC, 8'h05);
    write_reg(ADDR_TMA, rng[23:16]);
    write_reg(ADDR_IE, 8'h04);
    write_reg(ADDR_TIMA, 8'hFE);
    for (int i = 0; i < LEN_STOP; i++) begin
      rng = lcg_next(rng);
      // Stop level flips now and then
      if (rng[31:27] == 5'd0) stp = ~stp;
      ack = (rng[20:19] == 2'd0);
      if (rng[26:21] == 6'd0) begin
        drive(1'b1, 1'b0, ADDR_TIMA, {4'hF, rng[3:0]}, 5'd0, 1'b0, stp);
      end else begin
        drive(1'b0, 1'b1, rng[1] ? (rng[0] ? ADDR_IF : ADDR_TIMA) : ADDR_DIV,
              8'h00, 5'd0, ack, stp);
      end
    end
    end_test("stop_freeze");
  endtask

  // ================================================
  // Sequence
  // ================================================

  initial begin
    rng = 32'h4f7f_d529;
    reset    <= 1'b1;
    stop     <= 1'b0;
    addr     <= 16'h0000;
    wdata    <= 8'h00;
    write_en <= 1'b0;
    read_en  <= 1'b0;
    ext_req  <= 5'd0;
    irq_ack  <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    probe_reset_values();
    exercise_div();
    sweep_tac_rates();
    force_overflows();
    stress_irq_priority();
    toggle_stop();
    $display("tests passed %0d failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, check_count, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* gb_timer_io.f */
hw/gb_types_pkg.sv
hw/gb_io_map_pkg.sv
hw/phase_sequencer.sv
hw/timer.sv
hw/interrupt_ctrl.sv
hw/gb_timer_io.sv
test/timer_checker.sv
test/tb_gb_timer_io.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --top-module tb_gb_timer_io -f gb_timer_io.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "STATUS: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
